// File: Makefile
# Verilator simulation of the game port testbench

VERILATOR ?= verilator
TOP       ?= tb_gameport
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: axis_timer.sv
// Axis pulse length is 101 clocks per count; no analog calibration, stick bytes are used as is
`include "gameport_params.svh"

module axis_timer (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       fire,
	input  gameport_pkg::pad_t         pad1,
	input  gameport_pkg::pad_t         pad2,
	input  gameport_pkg::stick_t       stick1,
	input  gameport_pkg::stick_t       stick2,
	output gameport_pkg::axis_active_t axis_active
);

	import gameport_pkg::*;

	// Counts 0 to GP_TICK_DIV, one step period per wrap
	logic [6:0] tick_div;
	// 0 p1 x, 1 p1 y, 2 p2 x, 3 p2 y
	axis_val_t  cnt [4];
	axis_val_t  load_val [4];
	// Sticky source per player, 1 means analog
	logic [1:0] use_ana;
	pad_t       pad_a [2];
	stick_t     stick_a [2];

	// Stick byte strictly inside the detect window
	function automatic logic in_window(input logic [7:0] b);
		return (b > `GP_DZ_LO) && (b < `GP_DZ_HI);
	endfunction

	// Signed byte to offset binary
	function automatic axis_val_t ana_load(input logic [7:0] b);
		return {~b[7], b[6:0]};
	endfunction

	// Low direction wins over high
	function automatic axis_val_t dig_load(input logic lo, input logic hi);
		if (lo) return `GP_AXIS_MIN;
		if (hi) return `GP_AXIS_MAX;
		return `GP_AXIS_CTR;
	endfunction

	assign pad_a[0]   = pad1;
	assign pad_a[1]   = pad2;
	assign stick_a[0] = stick1;
	assign stick_a[1] = stick2;

	// ==========================================================
	// Source selection
	// ==========================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			use_ana <= 2'b00;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (in_window(stick_a[p].x) || in_window(stick_a[p].y)) begin
					use_ana[p] <= 1'b1;
				end else if (pad_a[p].right || pad_a[p].left || pad_a[p].down ||
					pad_a[p].up) begin
					// D-pad pressed with the stick parked at an edge
					use_ana[p] <= 1'b0;
				end
			end
		end
	end

	// Load values from the current source
	always_comb begin
		for (int p = 0; p < 2; p++) begin
			if (use_ana[p]) begin
				load_val[2*p]   = ana_load(stick_a[p].x);
				load_val[2*p+1] = ana_load(stick_a[p].y);
			end else begin
				load_val[2*p]   = dig_load(pad_a[p].left, pad_a[p].right);
				load_val[2*p+1] = dig_load(pad_a[p].up, pad_a[p].down);
			end
		end
	end

	// ==========================================================
	// Prescaler and one-shot counters
	// ==========================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tick_div <= 7'd0;
			for (int i = 0; i < 4; i++) begin
				cnt[i] <= `GP_AXIS_CTR;
			end
		end else if (fire) begin
			// Restart so the first step comes a full period later
			tick_div <= 7'd0;
			for (int i = 0; i < 4; i++) begin
				cnt[i] <= load_val[i];
			end
		end else if (tick_div == `GP_TICK_DIV) begin
			tick_div <= 7'd0;
			for (int i = 0; i < 4; i++) begin
				// Hold at zero
				if (cnt[i] != 8'd0) cnt[i] <= cnt[i] - 8'd1;
			end
		end else begin
			tick_div <= tick_div + 7'd1;
		end
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			axis_active[i] = (cnt[i] != 8'd0);
		end
	end

endmodule

// File: gameport_assert.sv
// Bound into axis_timer; a counter may only rise on the edge that loads it from fire
module gameport_assert (
	input logic                       clk,
	input logic                       rst_n,
	input logic                       fire,
	input gameport_pkg::axis_val_t    cnt [4],
	input gameport_pkg::axis_active_t axis_active
);

	import gameport_pkg::*;

	// ==========================================================
	// Fire pulse and reset state
	// ==========================================================
	// Single-cycle start pulse
	a_fire_single: assert property (@(posedge clk) disable iff (!rst_n) fire |=> !fire)
		else $error("fire high for two consecutive cycles");

	// Counters come out of reset at the centre preset
	a_reset_flags: assert property (@(posedge clk) $rose(rst_n) |-> (axis_active == 4'hf))
		else $error("axis flags not all high after reset release");

	// ==========================================================
	// Counter direction
	// ==========================================================
	for (genvar i = 0; i < 4; i++) begin : g_cnt
		// Count down or hold, load only after fire
		a_cnt_no_rise: assert property (@(posedge clk) disable iff (!rst_n)
			!$past(fire) |-> (cnt[i] <= $past(cnt[i])))
			else $error("axis counter %0d rose without fire", i);
	end

endmodule

// File: gameport_params.svh
// Constants assume a clock near 90.5 MHz; the prescaler count and axis presets are fixed
`ifndef GAMEPORT_PARAMS_SVH
`define GAMEPORT_PARAMS_SVH

// ==========================================================
// APB register addresses (byte offsets, 4-bit decode)
// ==========================================================
`define GP_ADDR_PORT 4'h0
`define GP_ADDR_CTRL 4'h4
`define GP_ADDR_RATE 4'h8

// ==========================================================
// Axis timing
// ==========================================================
// Prescaler terminal count, counters step every 101 clocks
`define GP_TICK_DIV 7'd100

// Digital pad presets, left/up, centre, right/down
`define GP_AXIS_MIN 8'd4
`define GP_AXIS_CTR 8'd128
`define GP_AXIS_MAX 8'd252

// Exclusive bounds on the raw stick byte for analog detect
`define GP_DZ_LO 8'd60
`define GP_DZ_HI 8'd196

// ==========================================================
// Gravis serial clock
// ==========================================================
// Toggle rate in Hz, two toggles per 20 kHz bit
`define GP_GRAVIS_HZ 28'd40000
// Rate register after reset, in Hz
`define GP_RATE_RESET 28'd90500000

`endif

// File: gameport_pkg.sv
// Types only; pad bits are 1 when pressed and stick bytes are raw two's complement values
package gameport_pkg;

	// One axis timer count or preset
	typedef logic [7:0] axis_val_t;

	// System clock frequency in Hz
	typedef logic [27:0] rate_t;

	// Axis flags, bit 0 p1 x, bit 1 p1 y, bit 2 p2 x, bit 3 p2 y
	typedef logic [3:0] axis_active_t;

	// Operating mode, CTRL bits 1:0
	typedef enum logic [1:0] {
		GP_MODE_TWO    = 2'd0,
		GP_MODE_FOUR   = 2'd1,
		GP_MODE_GRAVIS = 2'd2,
		GP_MODE_OFF    = 2'd3
	} gp_mode_t;

	// Digital inputs of one player, first field is the top bit
	typedef struct packed {
		logic l2;
		logic r2;
		logic l1;
		logic r1;
		logic sel;
		logic start;
		logic but4;
		logic but3;
		logic but2;
		logic but1;
		logic up;
		logic down;
		logic left;
		logic right;
	} pad_t;

	// Analog stick, each byte signed and centred at 0
	typedef struct packed {
		logic [7:0] y;
		logic [7:0] x;
	} stick_t;

	// APB request without wait states
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

endpackage

// File: gameport_regs.sv
// Zero-wait APB slave without error response; PORT reads return the status byte one cycle old
`include "gameport_params.svh"

module gameport_regs (
	input  logic                       clk,
	input  logic                       rst_n,
	input  gameport_pkg::apb_req_t     req,
	output logic [31:0]                prdata,
	input  gameport_pkg::axis_active_t axis_active,
	input  logic                       grav_clk,
	input  logic [1:0]                 grav_data,
	input  gameport_pkg::pad_t         pad1,
	input  gameport_pkg::pad_t         pad2,
	output gameport_pkg::gp_mode_t     mode,
	output gameport_pkg::rate_t        rate,
	output logic                       fire
);

	import gameport_pkg::*;

	// Per-player disable, bit 0 P1, bit 1 P2
	logic [1:0] dis;
	logic       wr_en;
	logic       rd_en;
	// Disable flag spread over the four bit pairs of one half
	logic [3:0] player_dis;
	logic [3:0] btn_raw;
	logic [3:0] btn_dis;
	logic [7:0] status;

	// ==========================================================
	// APB decode
	// ==========================================================
	// Write lands at the end of the access cycle
	assign wr_en = req.psel && req.penable && req.pwrite;
	assign rd_en = req.psel && !req.pwrite;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mode <= GP_MODE_TWO;
			dis  <= 2'b00;
			rate <= `GP_RATE_RESET;
			fire <= 1'b0;
		end else begin
			// One-cycle start pulse for the axis timers, data ignored
			fire <= wr_en && (req.paddr == `GP_ADDR_PORT);
			if (wr_en && (req.paddr == `GP_ADDR_CTRL)) begin
				mode <= gp_mode_t'(req.pwdata[1:0]);
				dis  <= req.pwdata[3:2];
			end
			if (wr_en && (req.paddr == `GP_ADDR_RATE)) begin
				rate <= req.pwdata[27:0];
			end
		end
	end

	// Read mux, unmapped offsets give zero
	always_comb begin
		prdata = 32'h0;
		if (rd_en) begin
			case (req.paddr)
				`GP_ADDR_PORT: prdata = {24'h0, status};
				`GP_ADDR_CTRL: prdata = {28'h0, dis, mode};
				`GP_ADDR_RATE: prdata = {4'h0, rate};
				default:       prdata = 32'h0;
			endcase
		end
	end

	// ==========================================================
	// Status byte
	// ==========================================================
	assign player_dis = {dis[1], dis[1], dis[0], dis[0]};

	// Button half, low-active buttons or the raw serial lines
	always_comb begin
		case (mode)
			GP_MODE_FOUR: begin
				// All four buttons from P1
				btn_raw = {~pad1.but4, ~pad1.but3, ~pad1.but2, ~pad1.but1};
				btn_dis = {4{dis[0]}};
			end
			GP_MODE_GRAVIS: begin
				// Clock on 4 and 6, data on 5 (P1) and 7 (P2)
				btn_raw = {grav_data[1], grav_clk, grav_data[0], grav_clk};
				btn_dis = player_dis;
			end
			default: begin
				// Two buttons per player
				btn_raw = {~pad2.but2, ~pad2.but1, ~pad1.but2, ~pad1.but1};
				btn_dis = player_dis;
			end
		endcase
	end

	// Registered every cycle
	always_ff @(posedge clk) begin
		if (mode == GP_MODE_OFF) begin
			// Nothing attached, port floats high
			status <= 8'hff;
		end else begin
			status <= {btn_raw | btn_dis, axis_active | player_dis};
		end
	end

endmodule

// File: gameport_top.sv
// Single clock domain with synchronous reset; APB transfers complete in the access cycle
module gameport_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  gameport_pkg::apb_req_t req,
	output logic [31:0]            prdata,
	input  gameport_pkg::pad_t     pad1,
	input  gameport_pkg::pad_t     pad2,
	input  gameport_pkg::stick_t   stick1,
	input  gameport_pkg::stick_t   stick2
);

	import gameport_pkg::*;

	// Register block to timers
	logic         fire;
	rate_t        rate;
	// Back to the status byte
	axis_active_t axis_active;
	logic         grav_clk;
	logic [1:0]   grav_data;

	// ==========================================================
	// CPU registers and status byte
	// ==========================================================
	gameport_regs i_gameport_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.prdata      (prdata),
		.axis_active (axis_active),
		.grav_clk    (grav_clk),
		.grav_data   (grav_data),
		.pad1        (pad1),
		.pad2        (pad2),
		// Mode is consumed inside the register block only
		.mode        (),
		.rate        (rate),
		.fire        (fire)
	);

	// Axis one-shots
	axis_timer i_axis_timer (
		.clk         (clk),
		.rst_n       (rst_n),
		.fire        (fire),
		.pad1        (pad1),
		.pad2        (pad2),
		.stick1      (stick1),
		.stick2      (stick2),
		.axis_active (axis_active)
	);

	// Gravis GamePad Pro frames
	gravis_serializer i_gravis_serializer (
		.clk       (clk),
		.rst_n     (rst_n),
		.rate      (rate),
		.pad1      (pad1),
		.pad2      (pad2),
		.grav_clk  (grav_clk),
		.grav_data (grav_data)
	);

endmodule

// File: gravis_serializer.sv
// Serial clock is a plain register in clk; the rate must exceed GP_GRAVIS_HZ for a valid period
`include "gameport_params.svh"

module gravis_serializer (
	input  logic                clk,
	input  logic                rst_n,
	input  gameport_pkg::rate_t rate,
	input  gameport_pkg::pad_t  pad1,
	input  gameport_pkg::pad_t  pad2,
	output logic                grav_clk,
	output logic [1:0]          grav_data
);

	import gameport_pkg::*;

	// One bit wider than the rate so the sum never wraps
	logic [28:0] acc;
	logic [28:0] acc_sum;
	logic        grav_clk_q;
	logic        grav_rise;
	// Frame position 0 to 23
	logic [4:0]  pos;

	// Bit of one player's frame at a position, pressed is 1
	function automatic logic frame_bit(input pad_t pd, input logic [4:0] p);
		case (p)
			5'd1, 5'd2, 5'd3, 5'd4, 5'd5: return 1'b1;
			5'd7:  return pd.sel;
			5'd8:  return pd.start;
			5'd9:  return pd.r2;
			5'd10: return pd.but4;
			5'd12: return pd.l2;
			5'd13: return pd.but2;
			5'd14: return pd.but1;
			5'd15: return pd.but3;
			5'd17: return pd.l1;
			5'd18: return pd.r1;
			5'd19: return pd.up;
			5'd20: return pd.down;
			5'd22: return pd.right;
			5'd23: return pd.left;
			// Frame start and group separators
			default: return 1'b0;
		endcase
	endfunction

	// ==========================================================
	// Phase accumulator clock
	// ==========================================================
	assign acc_sum = acc + {1'b0, `GP_GRAVIS_HZ};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc      <= 29'd0;
			grav_clk <= 1'b0;
		end else if (acc_sum >= {1'b0, rate}) begin
			// Wrap keeps the remainder so the average rate is exact
			acc      <= acc_sum - {1'b0, rate};
			grav_clk <= ~grav_clk;
		end else begin
			acc <= acc_sum;
		end
	end

	// ==========================================================
	// Frame shifter
	// ==========================================================
	assign grav_rise = grav_clk && !grav_clk_q;

	// Data moves after the rising edge, steady at the falling one
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grav_clk_q <= 1'b0;
			pos        <= 5'd0;
			grav_data  <= 2'b00;
		end else begin
			grav_clk_q <= grav_clk;
			if (grav_rise) begin
				grav_data <= {frame_bit(pad2, pos), frame_bit(pad1, pos)};
				pos       <= (pos == 5'd23) ? 5'd0 : pos + 5'd1;
			end
		end
	end

endmodule

// File: list.f
+incdir+.
gameport_pkg.sv
gameport_regs.sv
axis_timer.sv
gravis_serializer.sv
gameport_top.sv
gameport_assert.sv
tb_gameport.sv

// File: tb_gameport.sv
// Params header on the include path; Gravis check sets RATE 800000 for a 20-clock half period
`include "gameport_params.svh"

module tb_gameport;

	import gameport_pkg::*;

	// Kinds of table entry
	localparam logic [1:0] K_STATUS = 2'd0;
	localparam logic [1:0] K_AXES   = 2'd1;
	localparam logic [1:0] K_FRAME  = 2'd2;
	localparam int NUM_ENTRIES = 13;
	// Longest axis pulse in clocks is 255 counts of 101
	localparam int LONGEST = 255 * 101;
	localparam int WATCHDOG_TIME = (NUM_ENTRIES + 2) * LONGEST * 10 + 100000;
	// Enough two-cycle reads for two whole frames
	localparam int FRAME_READS = 2000;

	typedef struct packed {
		logic [1:0]      kind;
		gp_mode_t        mode;
		logic [1:0]      dis;
		pad_t            pad1;
		pad_t            pad2;
		stick_t          stick1;
		stick_t          stick2;
		logic [7:0]      exp_status;
		// Order p2 y, p2 x, p1 y, p1 x from the top
		logic [3:0][7:0] exp_load;
	} entry_t;

	logic        clk;
	logic        rst_n;
	apb_req_t    req;
	logic [31:0] prdata;
	pad_t        pad1;
	pad_t        pad2;
	stick_t      stick1;
	stick_t      stick2;
	int          cycle = 0;
	int          errors = 0;
	int          checks = 0;
	int          last_wr = 0;
	int          last_rd = 0;
	logic [31:0] lcg_state;
	entry_t      stim [NUM_ENTRIES];

	gameport_top i_gameport_top (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (req),
		.prdata (prdata),
		.pad1   (pad1),
		.pad2   (pad2),
		.stick1 (stick1),
		.stick2 (stick2)
	);

	bind axis_timer gameport_assert i_gameport_assert (
		.clk         (clk),
		.rst_n       (rst_n),
		.fire        (fire),
		.cnt         (cnt),
		.axis_active (axis_active)
	);

	always #5 clk = ~clk;

	// Number of the latest rising edge when read 1 unit after it
	always @(posedge clk) cycle <= cycle + 1;

	// ==========================================================
	// Models and stimulus helpers
	// ==========================================================
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic pad_t make_pad(input logic l, input logic r, input logic u, input logic d);
		pad_t p;
		p = '0;
		p.left  = l;
		p.right = r;
		p.up    = u;
		p.down  = d;
		return p;
	endfunction

	// Status byte with all axes idle
	function automatic logic [7:0] status_model(input gp_mode_t m, input logic [1:0] d,
		input pad_t p1, input pad_t p2);
		logic [3:0] btn;
		if (m == GP_MODE_OFF) return 8'hff;
		if (m == GP_MODE_FOUR) begin
			btn = {~p1.but4, ~p1.but3, ~p1.but2, ~p1.but1} | {4{d[0]}};
		end else begin
			btn = {~p2.but2 | d[1], ~p2.but1 | d[1], ~p1.but2 | d[0], ~p1.but1 | d[0]};
		end
		return {btn, d[1], d[1], d[0], d[0]};
	endfunction

	// Frame positions 6 to 23 with the first bit on top
	function automatic logic [17:0] frame_model(input pad_t p);
		return {1'b0, p.sel, p.start, p.r2, p.but4, 1'b0, p.l2, p.but2, p.but1, p.but3,
			1'b0, p.l1, p.r1, p.up, p.down, 1'b0, p.right, p.left};
	endfunction

	// Entry with LCG pads and sticks parked at 0
	task automatic add_random(input int idx, input logic [1:0] k, input gp_mode_t m,
		input logic [1:0] d);
		entry_t e;
		e = '0;
		e.kind = k;
		e.mode = m;
		e.dis  = d;
		lcg_state = lcg_next(lcg_state);
		e.pad1 = pad_t'(lcg_state[29:16]);
		lcg_state = lcg_next(lcg_state);
		e.pad2 = pad_t'(lcg_state[29:16]);
		e.exp_status = status_model(m, d, e.pad1, e.pad2);
		stim[idx] = e;
	endtask

	task automatic add_axes(input int idx, input pad_t p1, input pad_t p2, input stick_t s1,
		input logic [3:0][7:0] loads);
		entry_t e;
		e = '0;
		e.kind     = K_AXES;
		e.mode     = GP_MODE_TWO;
		e.pad1     = p1;
		e.pad2     = p2;
		e.stick1   = s1;
		e.exp_load = loads;
		stim[idx] = e;
	endtask

	task automatic fill_table();
		add_random(0, K_STATUS, GP_MODE_TWO, 2'b00);
		add_random(1, K_STATUS, GP_MODE_TWO, 2'b00);
		add_random(2, K_STATUS, GP_MODE_FOUR, 2'b00);
		add_random(3, K_STATUS, GP_MODE_FOUR, 2'b00);
		add_random(4, K_STATUS, GP_MODE_TWO, 2'b01);
		add_random(5, K_STATUS, GP_MODE_TWO, 2'b10);
		add_random(6, K_STATUS, GP_MODE_FOUR, 2'b01);
		add_random(7, K_STATUS, GP_MODE_OFF, 2'b00);
		// Left and up win over right and down
		add_axes(8, make_pad(1, 0, 1, 0), make_pad(0, 1, 0, 1), 16'h0,
			{`GP_AXIS_MAX, `GP_AXIS_MAX, `GP_AXIS_MIN, `GP_AXIS_MIN});
		add_axes(9, make_pad(1, 1, 1, 1), make_pad(0, 0, 0, 0), 16'h0,
			{`GP_AXIS_CTR, `GP_AXIS_CTR, `GP_AXIS_MIN, `GP_AXIS_MIN});
		// Stick y 0xB0 and x 0x90 lie inside the window and load 48 and 16
		add_axes(10, make_pad(0, 0, 0, 0), make_pad(1, 0, 1, 0), {8'hb0, 8'h90},
			{`GP_AXIS_MIN, `GP_AXIS_MIN, 8'd48, 8'd16});
		// Left press with the stick back at the edge returns P1 to digital
		add_axes(11, make_pad(1, 0, 0, 0), make_pad(0, 0, 0, 0), 16'h0,
			{`GP_AXIS_CTR, `GP_AXIS_CTR, `GP_AXIS_CTR, `GP_AXIS_MIN});
		add_random(12, K_FRAME, GP_MODE_GRAVIS, 2'b00);
	endtask

	// ==========================================================
	// APB access tasks entered and left 1 unit after a rising edge
	// ==========================================================
	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
		req.psel    = 1'b1;
		req.penable = 1'b0;
		req.pwrite  = 1'b1;
		req.paddr   = addr;
		req.pwdata  = data;
		@(posedge clk);
		#1;
		req.penable = 1'b1;
		@(posedge clk);
		#1;
		last_wr = cycle;
		req = '0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
		req.psel    = 1'b1;
		req.penable = 1'b0;
		req.pwrite  = 1'b0;
		req.paddr   = addr;
		req.pwdata  = 32'h0;
		@(posedge clk);
		#1;
		req.penable = 1'b1;
		// Sample prdata mid access cycle
		@(negedge clk);
		data = prdata;
		last_rd = cycle;
		@(posedge clk);
		#1;
		req = '0;
	endtask

	task automatic expect_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
		end
	endtask

	// ==========================================================
	// Pulse and frame checks
	// ==========================================================
	// Flag must stay high below 101*N clocks and be gone past 101*N+4
	task automatic check_pulses(input int t0, input logic [3:0][7:0] n, input string what);
		logic [31:0] rd;
		logic [3:0]  bad;
		int          t;
		int          limit;
		bit          busy;
		bad   = 4'h0;
		limit = 0;
		busy  = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (int'(n[i]) * 101 > limit) limit = int'(n[i]) * 101;
		end
		limit = limit + 20;
		checks++;
		while (busy) begin
			apb_read(`GP_ADDR_PORT, rd);
			t = last_rd - t0;
			busy = 1'b0;
			for (int i = 0; i < 4; i++) begin
				// First two clocks still show the old counters
				if (!bad[i] && t >= 2 && !rd[i] && t < int'(n[i]) * 101) begin
					bad[i] = 1'b1;
					errors++;
					$display("FAIL %0t: %s axis %0d low after %0d clocks, load %0d",
						$time, what, i, t, n[i]);
				end
				if (!bad[i] && rd[i] && t > int'(n[i]) * 101 + 4) begin
					bad[i] = 1'b1;
					errors++;
					$display("FAIL %0t: %s axis %0d still high after %0d clocks, load %0d",
						$time, what, i, t, n[i]);
				end
				if (rd[i] && !bad[i]) busy = 1'b1;
			end
			if (t > limit) busy = 1'b0;
		end
	endtask

	// Sample bits 5 and 7 at each falling edge of bit 4 once five ones are seen
	task automatic capture_frame(output logic [17:0] f1, output logic [17:0] f2, output bit found);
		logic [31:0] rd;
		logic        prev_clk;
		int          ones;
		int          got;
		bit          collecting;
		f1         = 18'h0;
		f2         = 18'h0;
		found      = 1'b0;
		prev_clk   = 1'b0;
		ones       = 0;
		got        = 0;
		collecting = 1'b0;
		for (int k = 0; k < FRAME_READS && !found; k++) begin
			apb_read(`GP_ADDR_PORT, rd);
			if (prev_clk && !rd[4]) begin
				if (collecting) begin
					f1 = {f1[16:0], rd[5]};
					f2 = {f2[16:0], rd[7]};
					got++;
					if (got == 18) found = 1'b1;
				end else if (rd[5]) begin
					ones++;
					if (ones == 5) collecting = 1'b1;
				end else begin
					ones = 0;
				end
			end
			prev_clk = rd[4];
		end
	endtask

	task automatic apply_entry(input entry_t e);
		logic [31:0] rd;
		logic [17:0] f1;
		logic [17:0] f2;
		bit          found;
		pad1   = e.pad1;
		pad2   = e.pad2;
		stick1 = e.stick1;
		stick2 = e.stick2;
		apb_write(`GP_ADDR_CTRL, {28'h0, e.dis, e.mode});
		if (e.kind == K_STATUS) begin
			apb_read(`GP_ADDR_PORT, rd);
			checks++;
			if (rd[7:0] !== e.exp_status) begin
				errors++;
				$display("FAIL %0t: status 0x%02h, expected 0x%02h, mode %0d dis %b",
					$time, rd[7:0], e.exp_status, e.mode, e.dis);
			end
		end else if (e.kind == K_AXES) begin
			// Any data starts the timers
			lcg_state = lcg_next(lcg_state);
			apb_write(`GP_ADDR_PORT, lcg_state);
			check_pulses(last_wr, e.exp_load, "pulse");
		end else begin
			apb_write(`GP_ADDR_RATE, 32'd800000);
			capture_frame(f1, f2, found);
			checks++;
			if (!found) begin
				errors++;
				$display("No Gravis frame header seen on the status byte");
			end else begin
				if (f1 !== frame_model(e.pad1)) begin
					errors++;
					$display("FAIL %0t: P1 frame %b, expected %b", $time, f1, frame_model(e.pad1));
				end
				if (f2 !== frame_model(e.pad2)) begin
					errors++;
					$display("FAIL %0t: P2 frame %b, expected %b", $time, f2, frame_model(e.pad2));
				end
			end
		end
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================
	initial begin
		logic [31:0] rd;
		int          rel;
		clk       = 1'b0;
		rst_n     = 1'b0;
		req       = '0;
		pad1      = '0;
		pad2      = '0;
		stick1    = '0;
		stick2    = '0;
		lcg_state = 32'd37843;
		fill_table();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		rel = cycle;
		// Reset values and field masks
		apb_read(`GP_ADDR_CTRL, rd);
		expect_word(rd, 32'h0, "CTRL after reset");
		apb_read(`GP_ADDR_RATE, rd);
		expect_word(rd, {4'h0, `GP_RATE_RESET}, "RATE after reset");
		apb_write(`GP_ADDR_CTRL, 32'hffff_fff6);
		apb_read(`GP_ADDR_CTRL, rd);
		expect_word(rd, 32'h0000_0006, "CTRL masked");
		apb_write(`GP_ADDR_RATE, 32'hffff_ffff);
		apb_read(`GP_ADDR_RATE, rd);
		expect_word(rd, 32'h0fff_ffff, "RATE masked");
		apb_write(4'hc, 32'hffff_ffff);
		apb_read(4'hc, rd);
		expect_word(rd, 32'h0, "unmapped offset");
		apb_write(`GP_ADDR_CTRL, 32'h0);
		apb_read(`GP_ADDR_CTRL, rd);
		expect_word(rd, 32'h0, "CTRL cleared");
		apb_write(`GP_ADDR_RATE, {4'h0, `GP_RATE_RESET});
		// Reset counters run down from the centre preset
		check_pulses(rel, {4{`GP_AXIS_CTR}}, "reset");
		for (int k = 0; k < NUM_ENTRIES; k++) begin
			apply_entry(stim[k]);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_TIME);
		$display("Timeout: run went past %0d time units", WATCHDOG_TIME);
		$display("** FAIL **");
		$finish;
	end

endmodule
